// File: dcache_top.f
+incdir+source
source/dcache_pkg.sv
source/dcache_data_array.sv
source/dcache_tag_array.sv
source/dcache_lookup.sv
source/dcache_top.sv
sim/tb_dcache_top.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - source
    files:
      - source/dcache_pkg.sv
      - source/dcache_data_array.sv
      - source/dcache_tag_array.sv
      - source/dcache_lookup.sv
      - source/dcache_top.sv

  - target: simulation
    include_dirs:
      - source
    files:
      - sim/tb_dcache_top.sv

// File: sim/tb_dcache_top.sv
// ============================================================
// dcache testbench
// directed tests with a reference model of tags, valid bits
// and lines, plus LCG-driven back-to-back traffic
// ============================================================

`timescale 1ns/1ns

`include "dcache_cfg.svh"

module tb_dcache_top
    import dcache_pkg::*;
;

    localparam int NUM_LINES = 1 << `DCACHE_INDEX_W;
    localparam int RAND_REQS = 200;
    // cycles taken by reset and the directed tests
    localparam int DIRECTED_CYCLES = 40;
    // twice the expected run length plus a margin
    localparam int CYCLE_LIMIT = 2 * (RAND_REQS + DIRECTED_CYCLES) + 120;

    logic                      clk;
    logic                      rst_n;
    logic                      req_valid;
    dcache_op_e                req_op;
    logic [`DCACHE_ADDR_W-1:0] req_addr;
    byte_en_t                  req_byte_en;
    line_t                     req_wdata;
    logic                      resp_valid;
    logic                      resp_hit;
    line_t                     resp_rdata;

    // reference model
    tag_t  model_tag   [0:NUM_LINES-1];
    logic  model_valid [0:NUM_LINES-1];
    line_t model_line  [0:NUM_LINES-1];

    logic [31:0] lcg_state;
    int          cycle_count;
    int          error_count;
    int          check_count;
    int          test_count;

    dcache_top i_dcache_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_op      (req_op),
        .req_addr    (req_addr),
        .req_byte_en (req_byte_en),
        .req_wdata   (req_wdata),
        .resp_valid  (resp_valid),
        .resp_hit    (resp_hit),
        .resp_rdata  (resp_rdata)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [`DCACHE_ADDR_W-1:0] make_addr(input tag_t tag,
                                                            input index_t idx,
                                                            input logic [2:0] offset);
        return {tag, idx, offset};
    endfunction

    task automatic compare_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic compare_line(input string name, input line_t got, input line_t exp);
        check_count++;
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    // one request: predict from the model, update it, then check the response
    task automatic send_req(input dcache_op_e op, input logic [`DCACHE_ADDR_W-1:0] addr,
                            input byte_en_t be, input line_t wdata);
        index_t idx;
        tag_t   tag;
        logic   exp_hit;
        line_t  exp_line;
        idx = addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
        tag = addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
        exp_hit = model_valid[idx] && (model_tag[idx] == tag);
        exp_line = model_line[idx];
        case (op)
            OP_FILL: begin
                model_tag[idx] = tag;
                model_valid[idx] = 1'b1;
                model_line[idx] = wdata;
            end
            OP_STORE: begin
                if (exp_hit) begin
                    for (int b = 0; b < `DCACHE_LINE_BYTES; b++) begin
                        if (be[b]) begin
                            model_line[idx][b*8 +: 8] = wdata[b*8 +: 8];
                        end
                    end
                end
            end
            OP_INVAL: model_valid[idx] = 1'b0;
            default: ;
        endcase
        req_valid = 1'b1;
        req_op = op;
        req_addr = addr;
        req_byte_en = be;
        req_wdata = wdata;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        check_count++;
        if (resp_valid !== 1'b1) begin
            $display("no response one cycle after the %s request to 0x%h", op.name(), addr);
            error_count++;
        end else begin
            compare_bit("resp_hit", resp_hit, exp_hit);
            if (op == OP_LOAD && exp_hit) begin
                compare_line("resp_rdata", resp_rdata, exp_line);
            end
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        check_count++;
        if (resp_valid !== 1'b0) begin
            $display("resp_valid is high in a cycle that follows no request");
            error_count++;
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        test_count++;
        $display("test %s: %0d errors", name, error_count - errors_before);
    endtask

    task automatic reset_misses();
        int errs;
        errs = error_count;
        check_count++;
        if (resp_valid !== 1'b0 || resp_hit !== 1'b0) begin
            $display("response outputs are not low after reset");
            error_count++;
        end
        for (int i = 0; i < 4; i++) begin
            send_req(OP_LOAD, make_addr(23'h12, index_t'(i * 9), 3'd0), '0, '0);
            idle_cycle();
        end
        end_test("reset_misses", errs);
    endtask

    task automatic fill_then_load();
        logic [`DCACHE_ADDR_W-1:0] a;
        int errs;
        errs = error_count;
        a = make_addr(23'h0abcd, 6'd5, 3'd0);
        send_req(OP_FILL, a, '0, 64'h0123_4567_89ab_cdef);
        send_req(OP_LOAD, a, '0, '0);
        // refill of a present line
        send_req(OP_FILL, a, '0, 64'hfeed_face_cafe_f00d);
        send_req(OP_LOAD, a, '0, '0);
        end_test("fill_then_load", errs);
    endtask

    task automatic store_merge();
        logic [`DCACHE_ADDR_W-1:0] a;
        logic [`DCACHE_ADDR_W-1:0] b;
        int errs;
        errs = error_count;
        a = make_addr(23'h00321, 6'd12, 3'd4);
        b = make_addr(23'h00654, 6'd12, 3'd4);
        send_req(OP_FILL, a, '0, 64'h1111_2222_3333_4444);
        send_req(OP_STORE, a, 8'b1010_0101, 64'haaaa_bbbb_cccc_dddd);
        send_req(OP_LOAD, a, '0, '0);
        // same index, other tag: no write-allocate
        send_req(OP_STORE, b, 8'hff, 64'h5555_6666_7777_8888);
        send_req(OP_LOAD, a, '0, '0);
        end_test("store_merge", errs);
    endtask

    task automatic tag_conflict();
        logic [`DCACHE_ADDR_W-1:0] a;
        logic [`DCACHE_ADDR_W-1:0] b;
        int errs;
        errs = error_count;
        a = make_addr(23'h00111, 6'd20, 3'd0);
        b = make_addr(23'h00222, 6'd20, 3'd0);
        send_req(OP_FILL, a, '0, 64'h0a0a_0a0a_0a0a_0a0a);
        send_req(OP_FILL, b, '0, 64'h0b0b_0b0b_0b0b_0b0b);
        send_req(OP_LOAD, a, '0, '0);
        send_req(OP_LOAD, b, '0, '0);
        end_test("tag_conflict", errs);
    endtask

    task automatic invalidate_line();
        logic [`DCACHE_ADDR_W-1:0] a;
        int errs;
        errs = error_count;
        a = make_addr(23'h07070, 6'd33, 3'd0);
        send_req(OP_FILL, a, '0, 64'h0f0f_f0f0_0f0f_f0f0);
        send_req(OP_INVAL, a, '0, '0);
        send_req(OP_LOAD, a, '0, '0);
        send_req(OP_INVAL, a, '0, '0);
        send_req(OP_INVAL, make_addr(23'h07070, 6'd40, 3'd0), '0, '0);
        end_test("invalidate_line", errs);
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        logic [31:0] d_hi;
        logic [31:0] d_lo;
        logic [31:0] m;
        tag_t        tag;
        index_t      idx;
        int          errs;
        errs = error_count;
        for (int n = 0; n < RAND_REQS; n++) begin
            // upper LCG bits, the low ones repeat quickly
            r = next_rand();
            m = next_rand();
            d_hi = next_rand();
            d_lo = next_rand();
            tag = 23'h00040 + tag_t'(r[29:28]);
            idx = {3'b000, r[27:25]};
            send_req(dcache_op_e'(r[31:30]), make_addr(tag, idx, r[24:22]),
                     m[31:24], {d_hi, d_lo});
        end
        end_test("random_traffic", errs);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        req_valid = 1'b0;
        req_op = OP_LOAD;
        req_addr = '0;
        req_byte_en = '0;
        req_wdata = '0;
        lcg_state = 32'ha1b0;
        cycle_count = 0;
        error_count = 0;
        check_count = 0;
        test_count = 0;
        for (int i = 0; i < NUM_LINES; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i] = '0;
            model_line[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        reset_misses();
        fill_then_load();
        store_merge();
        tag_conflict();
        invalidate_line();
        random_traffic();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: source/dcache_top.sv
// ============================================================
// dcache top
// address split, data array, tag array and lookup
// ============================================================

`timescale 1ns/1ns

`include "dcache_cfg.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid,
    input  dcache_op_e                req_op,
    input  logic [`DCACHE_ADDR_W-1:0] req_addr,
    input  byte_en_t                  req_byte_en,
    input  line_t                     req_wdata,
    output logic                      resp_valid,
    output logic                      resp_hit,
    output line_t                     resp_rdata
);

    index_t   req_index;
    tag_t     req_tag;

    tag_t     rd_tag;
    logic     rd_valid;
    line_t    rd_data;

    logic     tag_wr_en;
    tag_t     wr_tag;
    logic     valid_wr_en;
    logic     wr_valid;
    byte_en_t byte_wr_en;
    line_t    wr_data;

    // offset bits dropped, accesses are whole-line
    assign req_index = req_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign req_tag   = req_addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];

    dcache_data_array i_data_array (
        .clk        (clk),
        .index      (req_index),
        .byte_wr_en (byte_wr_en),
        .wr_data    (wr_data),
        .rd_data    (rd_data)
    );

    dcache_tag_array i_tag_array (
        .clk         (clk),
        .rst_n       (rst_n),
        .index       (req_index),
        .tag_wr_en   (tag_wr_en),
        .wr_tag      (wr_tag),
        .valid_wr_en (valid_wr_en),
        .wr_valid    (wr_valid),
        .rd_tag      (rd_tag),
        .rd_valid    (rd_valid)
    );

    dcache_lookup i_lookup (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_op      (req_op),
        .req_tag     (req_tag),
        .req_byte_en (req_byte_en),
        .req_wdata   (req_wdata),
        .rd_tag      (rd_tag),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .tag_wr_en   (tag_wr_en),
        .wr_tag      (wr_tag),
        .valid_wr_en (valid_wr_en),
        .wr_valid    (wr_valid),
        .byte_wr_en  (byte_wr_en),
        .wr_data     (wr_data),
        .resp_valid  (resp_valid),
        .resp_hit    (resp_hit),
        .resp_rdata  (resp_rdata)
    );

endmodule

// File: source/dcache_lookup.sv
// ============================================================
// dcache lookup
// tag compare, array write enables, registered response
// ============================================================

`timescale 1ns/1ns

module dcache_lookup
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // request
    input  logic       req_valid,
    input  dcache_op_e req_op,
    input  tag_t       req_tag,
    input  byte_en_t   req_byte_en,
    input  line_t      req_wdata,

    // array read side
    input  tag_t       rd_tag,
    input  logic       rd_valid,
    input  line_t      rd_data,

    // array write side
    output logic       tag_wr_en,
    output tag_t       wr_tag,
    output logic       valid_wr_en,
    output logic       wr_valid,
    output byte_en_t   byte_wr_en,
    output line_t      wr_data,

    // response
    output logic       resp_valid,
    output logic       resp_hit,
    output line_t      resp_rdata
);

    logic hit;

    // state of the line before this request writes it
    assign hit = rd_valid && (rd_tag == req_tag);

    // a fill brings the new tag, everything else leaves it
    assign wr_tag = req_tag;

    // fill sets valid, invalidate clears it
    assign wr_valid = (req_op == OP_FILL);

    // store data merges through the byte enables
    assign wr_data = req_wdata;

    always_comb begin
        tag_wr_en   = 1'b0;
        valid_wr_en = 1'b0;
        byte_wr_en  = '0;
        if (req_valid) begin
            case (req_op)
                OP_FILL: begin
                    tag_wr_en   = 1'b1;
                    valid_wr_en = 1'b1;
                    byte_wr_en  = '1;
                end
                OP_STORE: begin
                    // no write-allocate
                    if (hit) begin
                        byte_wr_en = req_byte_en;
                    end
                end
                OP_INVAL: begin
                    valid_wr_en = 1'b1;
                end
                default: begin
                    // load writes nothing
                end
            endcase
        end
    end

    // response one cycle after the request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
            resp_hit   <= 1'b0;
        end else begin
            resp_valid <= req_valid;
            if (req_valid) begin
                resp_hit <= hit;
            end
        end
    end

    // read data only matters for a load hit
    always_ff @(posedge clk) begin
        if (req_valid) begin
            resp_rdata <= rd_data;
        end
    end

endmodule

// File: source/dcache_tag_array.sv
// ============================================================
// dcache tag and valid store
// 64 x 23-bit tags, 64 valid bits, async read
// ============================================================

`timescale 1ns/1ns

`include "dcache_cfg.svh"

module dcache_tag_array
    import dcache_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  index_t index,
    input  logic   tag_wr_en,
    input  tag_t   wr_tag,
    input  logic   valid_wr_en,
    input  logic   wr_valid,
    output tag_t   rd_tag,
    output logic   rd_valid
);

    localparam int NUM_LINES = 1 << `DCACHE_INDEX_W;

    tag_t                 tag_mem [0:NUM_LINES-1];
    logic [NUM_LINES-1:0] valid_q;

    // tag store
    always_ff @(posedge clk) begin
        if (tag_wr_en) begin
            tag_mem[index] <= wr_tag;
        end
    end

    // valid bits, written separately so an invalidate keeps the tag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (valid_wr_en) begin
            valid_q[index] <= wr_valid;
        end
    end

    assign rd_tag   = tag_mem[index];
    assign rd_valid = valid_q[index];

endmodule

// File: source/dcache_data_array.sv
// ============================================================
// dcache data array
// 64 x 64-bit lines, async read, byte-masked clocked write
// ============================================================

`timescale 1ns/1ns

`include "dcache_cfg.svh"

module dcache_data_array
    import dcache_pkg::*;
(
    input  logic     clk,
    input  index_t   index,
    input  byte_en_t byte_wr_en,
    input  line_t    wr_data,
    output line_t    rd_data
);

    localparam int NUM_LINES = 1 << `DCACHE_INDEX_W;

    line_t mem [0:NUM_LINES-1];

    // each enabled byte lane writes on its own
    always_ff @(posedge clk) begin
        for (int b = 0; b < `DCACHE_LINE_BYTES; b++) begin
            if (byte_wr_en[b]) begin
                mem[index][b*8 +: 8] <= wr_data[b*8 +: 8];
            end
        end
    end

    // read follows index
    assign rd_data = mem[index];

endmodule

// File: source/dcache_pkg.sv
// ============================================================
// dcache package
// operation codes and index, tag, line and byte mask types
// ============================================================

package dcache_pkg;

`include "dcache_cfg.svh"

    // request operation
    typedef enum logic [1:0] {
        OP_LOAD  = 2'd0,
        OP_STORE = 2'd1,
        OP_FILL  = 2'd2,
        OP_INVAL = 2'd3
    } dcache_op_e;

    typedef logic [`DCACHE_INDEX_W-1:0] index_t;

    typedef logic [`DCACHE_TAG_W-1:0] tag_t;

    typedef logic [`DCACHE_LINE_BYTES*8-1:0] line_t;

    // one enable per byte of a line
    typedef logic [`DCACHE_LINE_BYTES-1:0] byte_en_t;

endpackage

// File: source/dcache_cfg.svh
// ============================================================
// dcache geometry macros
// address split, line size and array depth
// ============================================================

`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// byte address
`define DCACHE_ADDR_W     32
`define DCACHE_OFFSET_W   3
// 64 lines
`define DCACHE_INDEX_W    6
// what is left of the address above index and offset
`define DCACHE_TAG_W      23
// 64-bit line
`define DCACHE_LINE_BYTES 8

`endif
